/* compile.f */
+incdir+hdl
hdl/dma_cluster_pkg.sv
hdl/dma_ctrl_pkg.sv
hdl/dma_req_cut.sv
hdl/dma_region_splitter.sv
hdl/dma_group_distributor.sv
hdl/dma_outstanding_counter.sv
hdl/dma_ctrl.sv
hdl/dma_cluster_top.sv
verif/dma_cluster_assert.sv
verif/dma_cluster_tb.sv

/* verif/dma_cluster_tb.sv */
// Testbench for the DMA cluster top level
// Random requests, group model with random ready and done pulses, watchdog
`timescale 1ns/100ps
`include "dma_cluster_params.svh"

module dma_cluster_tb;
  import dma_cluster_pkg::*;

  localparam int unsigned num_req    = 40;
  localparam int unsigned clk_period = 100;
  localparam logic [31:0] seed       = 32'h4c37;

  logic                            clk;
  logic                            rst_n;
  addr_t                           req_src, req_dst;
  len_t                            req_len;
  logic                            req_valid, req_ready;
  addr_t [`DMA_NUM_GROUPS-1:0]     grp_src, grp_dst;
  len_t  [`DMA_NUM_GROUPS-1:0]     grp_len;
  grp_mask_t                       grp_valid, grp_ready, grp_done, acc_pending;
  logic                            trans_complete, backend_idle;
  logic [31:0]                     req_rnd, grp_rnd;
  int unsigned                     cycle, completed;
  int unsigned                     due_q[`DMA_NUM_GROUPS][$];

  bind dma_cluster_top dma_cluster_assert u_assert (.load_i(load), .*);

  dma_cluster_top DUT (
    .clk_i           (clk           ),
    .rst_n_i         (rst_n         ),
    .req_src_i       (req_src       ),
    .req_dst_i       (req_dst       ),
    .req_len_i       (req_len       ),
    .req_valid_i     (req_valid     ),
    .req_ready_o     (req_ready     ),
    .grp_src_o       (grp_src       ),
    .grp_dst_o       (grp_dst       ),
    .grp_len_o       (grp_len       ),
    .grp_valid_o     (grp_valid     ),
    .grp_ready_i     (grp_ready     ),
    .grp_done_i      (grp_done      ),
    .trans_complete_o(trans_complete),
    .backend_idle_o  (backend_idle  )
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Ready only changes on clock edges, so its value here holds for the next edge
  task automatic send_request(input addr_t src, input addr_t dst, input len_t len);
    logic taken;
    req_src   = src;
    req_dst   = dst;
    req_len   = len;
    req_valid = 1'b1;
    do begin
      taken = req_ready;
      @(posedge clk);
      #10;
    end while (!taken);
    req_valid = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    addr_t src, dst;
    len_t  len;
    rst_n     = 1'b1;
    req_src   = '0;
    req_dst   = '0;
    req_len   = '0;
    req_valid = 1'b0;
    grp_ready = '0;
    grp_done  = '0;
    req_rnd   = seed;
    #1 rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #10 rst_n = 1'b1;
    for (int i = 0; i < num_req; i++) begin
      req_rnd = xorshift(req_rnd);
      dst     = {4'h0, req_rnd[11:2], 2'b00};
      src     = {req_rnd[29:16], 2'b00};
      req_rnd = xorshift(req_rnd);
      len     = len_t'(4 * (1 + req_rnd % 50));
      // Slice crossing, then region crossing
      if (i == 0) begin
        dst = 16'h000c;
        len = 16'd8;
      end
      if (i == 1) begin
        dst = 16'h0038;
        len = 16'd80;
      end
      send_request(src, dst, len);
      if (req_rnd[17:16] == 2'b11) begin
        repeat (3) @(posedge clk);
        #10;
      end
    end
    wait (completed == num_req);
    repeat (4) @(posedge clk);
    if (DUT.u_assert.failed) begin
      $display("Errors found");
      $fatal(1, "An assertion failed during the run");
    end else begin
      $display("No errors");
      $finish;
    end
  end

  // Group model with a done pulse 1 to 8 cycles after each accepted piece
  initial begin
    grp_rnd     = xorshift(~seed);
    cycle       = 0;
    completed   = 0;
    acc_pending = '0;
    wait (!rst_n);
    @(posedge rst_n);
    forever begin
      @(posedge clk);
      #10;
      cycle++;
      if (trans_complete) completed++;
      for (int g = 0; g < `DMA_NUM_GROUPS; g++) begin
        grp_rnd = xorshift(grp_rnd);
        if (acc_pending[g]) due_q[g].push_back(cycle + grp_rnd[2:0]);
        grp_done[g] = (due_q[g].size() > 0) && (due_q[g][0] <= cycle);
        if (grp_done[g]) void'(due_q[g].pop_front());
      end
      grp_rnd     = xorshift(grp_rnd);
      grp_ready   = grp_rnd[3:0] | grp_rnd[7:4];
      acc_pending = grp_valid & grp_ready;
    end
  end

  initial begin
    wait (DUT.u_assert.failed);
    $display("Errors found");
    $fatal(1, "Stopped at the first failed assertion");
  end

  initial begin
    repeat (num_req * 300) @(posedge clk);
    $display("Errors found");
    $fatal(1, "Timeout: requests not completed within %0d cycles", num_req * 300);
  end

endmodule

/* verif/dma_cluster_assert.sv */
// Bound checker for the DMA cluster top level
// Reset state, slice ownership, hold, conservation and completion
`timescale 1ns/100ps
`include "dma_cluster_params.svh"

module dma_cluster_assert (
  input logic                                         clk_i,
  input logic                                         rst_n_i,
  input dma_cluster_pkg::addr_t                       req_src_i,
  input dma_cluster_pkg::addr_t                       req_dst_i,
  input dma_cluster_pkg::len_t                        req_len_i,
  input logic                                         req_valid_i,
  input logic                                         req_ready_o,
  input dma_cluster_pkg::addr_t [`DMA_NUM_GROUPS-1:0] grp_src_o,
  input dma_cluster_pkg::addr_t [`DMA_NUM_GROUPS-1:0] grp_dst_o,
  input dma_cluster_pkg::len_t  [`DMA_NUM_GROUPS-1:0] grp_len_o,
  input dma_cluster_pkg::grp_mask_t                   grp_valid_o,
  input dma_cluster_pkg::grp_mask_t                   grp_ready_i,
  input dma_cluster_pkg::grp_mask_t                   grp_done_i,
  input logic                                         trans_complete_o,
  input logic                                         backend_idle_o,
  input logic                                         load_i
);
  import dma_cluster_pkg::*;

  addr_t      src_mem [64];
  addr_t      dst_mem [64];
  len_t       len_mem [64];
  logic [5:0] wr_ptr_q, rd_ptr_q;
  int         sum_q, outst_q, acc_bytes;
  logic       busy_q, pending;
  grp_mask_t  acc;
  addr_t      head_src, head_dst;
  len_t       head_len;
  bit         failed;

  assign acc      = grp_valid_o & grp_ready_i;
  assign pending  = (wr_ptr_q != rd_ptr_q);
  assign head_src = src_mem[rd_ptr_q];
  assign head_dst = dst_mem[rd_ptr_q];
  assign head_len = len_mem[rd_ptr_q];

  always_comb begin
    acc_bytes = 0;
    for (int g = 0; g < `DMA_NUM_GROUPS; g++) begin
      if (acc[g]) acc_bytes += int'(grp_len_o[g]);
    end
  end

  // Oldest open request, bytes accepted for it and pieces still out
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      sum_q    <= 0;
      outst_q  <= 0;
      busy_q   <= 1'b0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        src_mem[wr_ptr_q] <= req_src_i;
        dst_mem[wr_ptr_q] <= req_dst_i;
        len_mem[wr_ptr_q] <= req_len_i;
        wr_ptr_q          <= wr_ptr_q + 1'b1;
      end
      if (trans_complete_o) rd_ptr_q <= rd_ptr_q + 1'b1;
      sum_q   <= trans_complete_o ? acc_bytes : sum_q + acc_bytes;
      outst_q <= outst_q + $countones(acc) - $countones(grp_done_i);
      busy_q  <= load_i | (busy_q & ~trans_complete_o);
    end
  end

  assert property (@(posedge clk_i) (!rst_n_i || $rose(rst_n_i)) |->
      grp_valid_o == '0 && !trans_complete_o && backend_idle_o && req_ready_o)
    else begin
      failed = 1'b1;
      $error("ERR %0t: reset state valid=%b complete=%b idle=%b ready=%b", $time,
             $sampled(grp_valid_o), $sampled(trans_complete_o),
             $sampled(backend_idle_o), $sampled(req_ready_o));
    end

  for (genvar g = 0; g < `DMA_NUM_GROUPS; g++) begin : g_grp
    assert property (@(posedge clk_i) disable iff (!rst_n_i) grp_valid_o[g] |->
        (grp_dst_o[g] / `DMA_SLICE_BYTES) % `DMA_NUM_GROUPS == g &&
        grp_dst_o[g] % `DMA_SLICE_BYTES + grp_len_o[g] <= `DMA_SLICE_BYTES &&
        grp_len_o[g] != '0)
      else begin
        failed = 1'b1;
        $error("ERR %0t: group %0d piece dst=%h len=%0d outside its slice", $time, g,
               $sampled(grp_dst_o[g]), $sampled(grp_len_o[g]));
      end

    // Stalled piece keeps valid and fields
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        grp_valid_o[g] && !grp_ready_i[g] |=> grp_valid_o[g] &&
        $stable(grp_src_o[g]) && $stable(grp_dst_o[g]) && $stable(grp_len_o[g]))
      else begin
        failed = 1'b1;
        $error("ERR %0t: group %0d piece changed under back-pressure, dst=%h len=%0d",
               $time, g, $sampled(grp_dst_o[g]), $sampled(grp_len_o[g]));
      end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) acc[g] |->
        pending && addr_t'(grp_src_o[g] - grp_dst_o[g]) == addr_t'(head_src - head_dst) &&
        grp_dst_o[g] >= head_dst &&
        int'(grp_dst_o[g]) + int'(grp_len_o[g]) <= int'(head_dst) + int'(head_len))
      else begin
        failed = 1'b1;
        $error("ERR %0t: group %0d piece src=%h dst=%h len=%0d, request src=%h dst=%h len=%0d",
               $time, g, $sampled(grp_src_o[g]), $sampled(grp_dst_o[g]),
               $sampled(grp_len_o[g]), $sampled(head_src), $sampled(head_dst),
               $sampled(head_len));
      end
  end

  // One pulse per request after all its bytes and done pulses
  assert property (@(posedge clk_i) disable iff (!rst_n_i) trans_complete_o |->
      pending && sum_q == int'(head_len) && outst_q == 0)
    else begin
      failed = 1'b1;
      $error("ERR %0t: completion with bytes=%0d of %0d, outstanding=%0d, open=%b",
             $time, $sampled(sum_q), $sampled(head_len), $sampled(outst_q),
             $sampled(pending));
    end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) backend_idle_o == !busy_q)
    else begin
      failed = 1'b1;
      $error("ERR %0t: idle=%b while busy=%b", $time, $sampled(backend_idle_o),
             $sampled(busy_q));
    end

endmodule

/* hdl/dma_cluster_top.sv */
// DMA cluster top level
// Request cut, region splitter, group distributor, counter and controller
`timescale 1ns/100ps
`include "dma_cluster_params.svh"

module dma_cluster_top (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  dma_cluster_pkg::addr_t                       req_src_i,
  input  dma_cluster_pkg::addr_t                       req_dst_i,
  input  dma_cluster_pkg::len_t                        req_len_i,
  input  logic                                         req_valid_i,
  output logic                                         req_ready_o,
  output dma_cluster_pkg::addr_t [`DMA_NUM_GROUPS-1:0] grp_src_o,
  output dma_cluster_pkg::addr_t [`DMA_NUM_GROUPS-1:0] grp_dst_o,
  output dma_cluster_pkg::len_t  [`DMA_NUM_GROUPS-1:0] grp_len_o,
  output dma_cluster_pkg::grp_mask_t                   grp_valid_o,
  input  dma_cluster_pkg::grp_mask_t                   grp_ready_i,
  input  dma_cluster_pkg::grp_mask_t                   grp_done_i,
  output logic                                         trans_complete_o,
  output logic                                         backend_idle_o
);

  dma_cluster_pkg::addr_t    cut_src, cut_dst, chunk_src, chunk_dst;
  dma_cluster_pkg::len_t     cut_len, chunk_len;
  dma_cluster_pkg::grp_mask_t accepted;
  logic                      cut_valid;
  logic                      load;
  logic                      step;
  logic                      last_chunk;
  logic                      all_accepted;
  logic                      none_outstanding;

  dma_req_cut i_req_cut (
    .clk_i  (clk_i      ),
    .rst_n_i(rst_n_i    ),
    .src_i  (req_src_i  ),
    .dst_i  (req_dst_i  ),
    .len_i  (req_len_i  ),
    .valid_i(req_valid_i),
    .ready_o(req_ready_o),
    .src_o  (cut_src    ),
    .dst_o  (cut_dst    ),
    .len_o  (cut_len    ),
    .valid_o(cut_valid  ),
    .pop_i  (load       )
  );

  dma_region_splitter i_region_splitter (
    .clk_i       (clk_i     ),
    .rst_n_i     (rst_n_i   ),
    .load_i      (load      ),
    .step_i      (step      ),
    .src_i       (cut_src   ),
    .dst_i       (cut_dst   ),
    .len_i       (cut_len   ),
    .chunk_src_o (chunk_src ),
    .chunk_dst_o (chunk_dst ),
    .chunk_len_o (chunk_len ),
    .last_chunk_o(last_chunk)
  );

  dma_group_distributor i_group_distributor (
    .clk_i         (clk_i       ),
    .rst_n_i       (rst_n_i     ),
    .step_i        (step        ),
    .chunk_src_i   (chunk_src   ),
    .chunk_dst_i   (chunk_dst   ),
    .chunk_len_i   (chunk_len   ),
    .grp_ready_i   (grp_ready_i ),
    .grp_src_o     (grp_src_o   ),
    .grp_dst_o     (grp_dst_o   ),
    .grp_len_o     (grp_len_o   ),
    .grp_valid_o   (grp_valid_o ),
    .accepted_o    (accepted    ),
    .all_accepted_o(all_accepted)
  );

  dma_outstanding_counter i_outstanding_counter (
    .clk_i             (clk_i           ),
    .rst_n_i           (rst_n_i         ),
    .accepted_i        (accepted        ),
    .done_i            (grp_done_i      ),
    .none_outstanding_o(none_outstanding)
  );

  dma_ctrl i_ctrl (
    .clk_i             (clk_i           ),
    .rst_n_i           (rst_n_i         ),
    .cut_valid_i       (cut_valid       ),
    .last_chunk_i      (last_chunk      ),
    .all_accepted_i    (all_accepted    ),
    .none_outstanding_i(none_outstanding),
    .load_o            (load            ),
    .step_o            (step            ),
    .trans_complete_o  (trans_complete_o),
    .backend_idle_o    (backend_idle_o  )
  );

endmodule

/* hdl/dma_ctrl.sv */
// Burst sequencing FSM
// Registered completion pulse and idle status
`timescale 1ns/100ps

module dma_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic cut_valid_i,
  input  logic last_chunk_i,
  input  logic all_accepted_i,
  input  logic none_outstanding_i,
  output logic load_o,
  output logic step_o,
  output logic trans_complete_o,
  output logic backend_idle_o
);
  import dma_ctrl_pkg::*;

  ctrl_state_e state_q, state_d;
  logic        last_q;
  logic        trans_complete_d;
  logic        backend_idle_d;

  always_comb begin
    state_d          = state_q;
    load_o           = 1'b0;
    step_o           = 1'b0;
    trans_complete_d = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (cut_valid_i) begin
          load_o  = 1'b1;
          state_d = ST_ISSUE;
        end
      end
      ST_ISSUE: begin
        step_o  = 1'b1;
        state_d = ST_WAIT_ACCEPT;
      end
      ST_WAIT_ACCEPT: begin
        if (all_accepted_i) begin
          state_d = last_q ? ST_WAIT_DONE : ST_ISSUE;
        end
      end
      ST_WAIT_DONE: begin
        if (none_outstanding_i) begin
          state_d          = ST_IDLE;
          trans_complete_d = 1'b1;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Busy as soon as a request is taken from the cut
  assign backend_idle_d = (state_q == ST_IDLE) & ~load_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q          <= ST_IDLE;
      last_q           <= 1'b0;
      trans_complete_o <= 1'b0;
      backend_idle_o   <= 1'b1;
    end else begin
      state_q          <= state_d;
      trans_complete_o <= trans_complete_d;
      backend_idle_o   <= backend_idle_d;
      // Splitter moves on after step, so remember whether this chunk ends the burst
      if (step_o) last_q <= last_chunk_i;
    end
  end

endmodule

/* hdl/dma_outstanding_counter.sv */
// Count of group pieces accepted but not yet reported done
`timescale 1ns/100ps
`include "dma_cluster_params.svh"

module dma_outstanding_counter (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  dma_cluster_pkg::grp_mask_t accepted_i,
  input  dma_cluster_pkg::grp_mask_t done_i,
  output logic                       none_outstanding_o
);
  import dma_cluster_pkg::*;

  cnt_t cnt_q, cnt_d;

  // Accepts and done pulses of the same cycle net out
  assign cnt_d = cnt_q + cnt_t'($countones(accepted_i)) - cnt_t'($countones(done_i));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign none_outstanding_o = (cnt_q == '0);

  if (`DMA_CNT_WIDTH <= $clog2(`DMA_NUM_GROUPS + 1))
    $fatal(1, "[dma_outstanding_counter] Counter too narrow for the group count.");

endmodule

/* hdl/dma_group_distributor.sv */
// Per-group piece extraction from a region-bounded chunk
// Each piece is held with its valid until the group accepts it
`timescale 1ns/100ps
`include "dma_cluster_params.svh"

module dma_group_distributor (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  logic                                           step_i,
  input  dma_cluster_pkg::addr_t                         chunk_src_i,
  input  dma_cluster_pkg::addr_t                         chunk_dst_i,
  input  dma_cluster_pkg::len_t                          chunk_len_i,
  input  dma_cluster_pkg::grp_mask_t                     grp_ready_i,
  output dma_cluster_pkg::addr_t [`DMA_NUM_GROUPS-1:0]   grp_src_o,
  output dma_cluster_pkg::addr_t [`DMA_NUM_GROUPS-1:0]   grp_dst_o,
  output dma_cluster_pkg::len_t  [`DMA_NUM_GROUPS-1:0]   grp_len_o,
  output dma_cluster_pkg::grp_mask_t                     grp_valid_o,
  output dma_cluster_pkg::grp_mask_t                     accepted_o,
  output logic                                           all_accepted_o
);
  import dma_cluster_pkg::*;

  localparam int unsigned region_aw = $clog2(`DMA_REGION_BYTES);

  // One extra bit so the chunk end can equal the region size
  typedef logic [region_aw:0] off_t;

  off_t                        chunk_off, chunk_end;
  off_t [`DMA_NUM_GROUPS-1:0]  piece_lo, piece_hi;
  grp_mask_t                   hit;
  grp_mask_t                   valid_q;

  assign chunk_off = off_t'(chunk_dst_i[region_aw-1:0]);
  assign chunk_end = chunk_off + off_t'(chunk_len_i);

  // Intersect the chunk with the slice of every group
  always_comb begin
    for (int g = 0; g < `DMA_NUM_GROUPS; g++) begin
      piece_lo[g] = (chunk_off > off_t'(g * `DMA_SLICE_BYTES)) ?
                    chunk_off : off_t'(g * `DMA_SLICE_BYTES);
      piece_hi[g] = (chunk_end < off_t'((g + 1) * `DMA_SLICE_BYTES)) ?
                    chunk_end : off_t'((g + 1) * `DMA_SLICE_BYTES);
      hit[g]      = piece_hi[g] > piece_lo[g];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (step_i) begin
      valid_q <= hit;
    end else begin
      valid_q <= valid_q & ~grp_ready_i;
    end
  end

  // Fields only load on a new chunk so a stalled piece stays stable
  always_ff @(posedge clk_i) begin
    if (step_i) begin
      for (int g = 0; g < `DMA_NUM_GROUPS; g++) begin
        grp_src_o[g] <= chunk_src_i + addr_t'(piece_lo[g] - chunk_off);
        grp_dst_o[g] <= chunk_dst_i + addr_t'(piece_lo[g] - chunk_off);
        grp_len_o[g] <= len_t'(piece_hi[g] - piece_lo[g]);
      end
    end
  end

  assign grp_valid_o    = valid_q;
  assign accepted_o     = valid_q & grp_ready_i;
  assign all_accepted_o = ~|(valid_q & ~grp_ready_i);

endmodule

/* hdl/dma_region_splitter.sv */
// Current burst registers and region-bounded chunk generation
`timescale 1ns/100ps
`include "dma_cluster_params.svh"

module dma_region_splitter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   load_i,
  input  logic                   step_i,
  input  dma_cluster_pkg::addr_t src_i,
  input  dma_cluster_pkg::addr_t dst_i,
  input  dma_cluster_pkg::len_t  len_i,
  output dma_cluster_pkg::addr_t chunk_src_o,
  output dma_cluster_pkg::addr_t chunk_dst_o,
  output dma_cluster_pkg::len_t  chunk_len_o,
  output logic                   last_chunk_o
);
  import dma_cluster_pkg::*;

  localparam int unsigned region_aw = $clog2(`DMA_REGION_BYTES);

  addr_t cur_src_q, cur_dst_q;
  len_t  rem_len_q, to_boundary, chunk_len;

  // Bytes left before the destination enters the next region
  assign to_boundary  = len_t'(`DMA_REGION_BYTES) - len_t'(cur_dst_q[region_aw-1:0]);
  assign chunk_len    = (rem_len_q < to_boundary) ? rem_len_q : to_boundary;
  assign last_chunk_o = (rem_len_q == chunk_len);
  assign chunk_src_o  = cur_src_q;
  assign chunk_dst_o  = cur_dst_q;
  assign chunk_len_o  = chunk_len;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rem_len_q <= '0;
    end else if (load_i) begin
      rem_len_q <= len_i;
    end else if (step_i) begin
      rem_len_q <= rem_len_q - chunk_len;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      cur_src_q <= src_i;
      cur_dst_q <= dst_i;
    end else if (step_i) begin
      cur_src_q <= cur_src_q + addr_t'(chunk_len);
      cur_dst_q <= cur_dst_q + addr_t'(chunk_len);
    end
  end

  if (`DMA_REGION_BYTES != (1 << region_aw))
    $fatal(1, "[dma_region_splitter] Region size must be a power of two.");

endmodule

/* hdl/dma_req_cut.sv */
// Two-entry spill register on the incoming burst request
`timescale 1ns/100ps

module dma_req_cut (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  dma_cluster_pkg::addr_t src_i,
  input  dma_cluster_pkg::addr_t dst_i,
  input  dma_cluster_pkg::len_t  len_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  output dma_cluster_pkg::addr_t src_o,
  output dma_cluster_pkg::addr_t dst_o,
  output dma_cluster_pkg::len_t  len_o,
  output logic                   valid_o,
  input  logic                   pop_i
);
  import dma_cluster_pkg::*;

  logic  a_full_q, b_full_q;
  logic  a_fill, a_drain, b_fill, b_drain;
  addr_t a_src_q, a_dst_q, b_src_q, b_dst_q;
  len_t  a_len_q, b_len_q;

  // Stage b only fills when the head stalls, and it is always the older entry
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~pop_i;
  assign b_drain = b_full_q & pop_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_src_q <= src_i;
      a_dst_q <= dst_i;
      a_len_q <= len_i;
    end
    if (b_fill) begin
      b_src_q <= a_src_q;
      b_dst_q <= a_dst_q;
      b_len_q <= a_len_q;
    end
  end

  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  assign src_o   = b_full_q ? b_src_q : a_src_q;
  assign dst_o   = b_full_q ? b_dst_q : a_dst_q;
  assign len_o   = b_full_q ? b_len_q : a_len_q;

endmodule

/* hdl/dma_ctrl_pkg.sv */
// DMA controller state encoding
package dma_ctrl_pkg;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT_ACCEPT,
    ST_WAIT_DONE
  } ctrl_state_e;

endpackage

/* hdl/dma_cluster_pkg.sv */
// Datapath types of the DMA cluster
// Addresses, byte lengths, group masks and the outstanding count
`include "dma_cluster_params.svh"

package dma_cluster_pkg;

  // Byte address, word-aligned
  typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;

  // Byte length, multiple of the word size
  typedef logic [`DMA_LEN_WIDTH-1:0] len_t;

  typedef logic [`DMA_NUM_GROUPS-1:0] grp_mask_t;

  typedef logic [`DMA_CNT_WIDTH-1:0] cnt_t;

endpackage

/* hdl/dma_cluster_params.svh */
// Sizing macros for the DMA cluster datapath
// Region size must be a power of two and the counter wider than a group count
`ifndef DMA_CLUSTER_PARAMS_SVH
`define DMA_CLUSTER_PARAMS_SVH

`define DMA_NUM_GROUPS      4
`define DMA_BANKS_PER_GROUP 4
`define DMA_WORD_BYTES      4

// Contiguous bytes one group owns in every region
`define DMA_SLICE_BYTES  (`DMA_BANKS_PER_GROUP * `DMA_WORD_BYTES)
`define DMA_REGION_BYTES (`DMA_SLICE_BYTES * `DMA_NUM_GROUPS)

`define DMA_ADDR_WIDTH 16
`define DMA_LEN_WIDTH  16
`define DMA_CNT_WIDTH  6

`endif
